/* Makefile */
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+') include/icache_consts.svh
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation reported failure, see $(LOG)"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
+incdir+include
verilog/icache_pkg.sv
verilog/icache_array.sv
verilog/icache_ctrl.sv
verilog/instr_mem.sv
verilog/icache_top.sv
testbench/icache_checker.sv
testbench/icache_tb.sv

/* include/icache_consts.svh */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// word address and instruction word
`define ADDR_W 16
`define DATA_W 32

// address split: index in the low bits, tag above it
`define INDEX_W 4
`define TAG_W 12

// one word per line
`define LINES 16

// cycles from a memory request to its response strobe, at least 2
`define MEM_LAT 4

`endif

/* testbench/icache_checker.sv */
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_req_valid,
    input  logic [`ADDR_W-1:0]    cpu_req_addr,
    input  logic                  cpu_ready,
    input  logic [`DATA_W-1:0]    cpu_data,
    input  logic                  mem_load_valid,
    input  icache_pkg::mem_load_t mem_load,
    output int                    error_count,
    output int                    fetch_count,
    output int                    hit_count
);

    import icache_pkg::*;

    // memory contents as loaded, and which tag sits in each line
    logic [`DATA_W-1:0] mem_model [2**`ADDR_W];
    logic               tag_valid [`LINES];
    logic [`TAG_W-1:0]  tag_table [`LINES];

    logic               busy = 1'b0;
    int                 latency = 0;
    logic [`ADDR_W-1:0] req_addr;
    logic [`DATA_W-1:0] exp_data;
    logic               exp_hit;
    int                 errors = 0;
    int                 fetches = 0;
    int                 hits = 0;

    assign error_count = errors;
    assign fetch_count = fetches;
    assign hit_count   = hits;

    // data of a fetch, and whether the line already holds its tag
    function automatic logic [`DATA_W-1:0] predict_fetch(input logic [`ADDR_W-1:0] addr,
                                                         output logic hit);
        logic [`INDEX_W-1:0] index;
        logic [`TAG_W-1:0]   tag;
        index = addr[`INDEX_W-1:0];
        tag   = addr[`ADDR_W-1:`INDEX_W];
        hit   = tag_valid[index] && (tag_table[index] == tag);
        return mem_model[addr];
    endfunction

    task automatic install_tag(input logic [`ADDR_W-1:0] addr);
        tag_valid[addr[`INDEX_W-1:0]] = 1'b1;
        tag_table[addr[`INDEX_W-1:0]] = addr[`ADDR_W-1:`INDEX_W];
    endtask

    // mid-cycle sampling, inputs move just after the rising edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            busy = 1'b0;
            for (int i = 0; i < `LINES; i++)
            begin
                tag_valid[i] = 1'b0;
            end
            if (cpu_ready)
            begin
                $display("cpu_ready went high during reset");
                errors++;
            end
        end
        else
        begin
            if (mem_load_valid)
            begin
                mem_model[mem_load.addr] = mem_load.data;
            end
            if (busy)
            begin
                latency++;
                if (cpu_ready)
                begin
                    if (cpu_data !== exp_data)
                    begin
                        $display("Fail cpu_data: got %h expected %h (addr %h)",
                                 cpu_data, exp_data, req_addr);
                        errors++;
                    end
                    if (exp_hit && latency != 1)
                    begin
                        $display("hit at addr %h answered after %0d cycles instead of 1",
                                 req_addr, latency);
                        errors++;
                    end
                    if (!exp_hit && latency <= 1)
                    begin
                        $display("miss at addr %h answered in a single cycle", req_addr);
                        errors++;
                    end
                    if (exp_hit)
                    begin
                        hits++;
                    end
                    fetches++;
                    install_tag(req_addr);
                    busy = 1'b0;
                end
            end
            else
            begin
                if (cpu_ready)
                begin
                    $display("cpu_ready went high with no fetch pending");
                    errors++;
                end
                // the DUT takes this request at the next rising edge
                if (cpu_req_valid)
                begin
                    busy     = 1'b1;
                    latency  = 0;
                    req_addr = cpu_req_addr;
                    exp_data = predict_fetch(cpu_req_addr, exp_hit);
                end
            end
        end
    end

endmodule

/* testbench/icache_tb.sv */
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tb;

    import icache_pkg::*;

    localparam int N_LOADS    = 64;
    localparam int N_DIRECTED = 6;
    localparam int N_RANDOM   = 400;
    localparam int N_FETCHES  = N_DIRECTED + N_RANDOM;
    // reset and loads, then every fetch at worst-case miss length, plus slack
    localparam int TIMEOUT_CYCLES = 10 + N_LOADS + 4 + N_FETCHES * (`MEM_LAT + 6) + 200;

    logic               clk;
    logic               rst;
    logic               cpu_req_valid;
    logic [`ADDR_W-1:0] cpu_req_addr;
    logic               cpu_ready;
    logic [`DATA_W-1:0] cpu_data;
    logic               mem_load_valid;
    mem_load_t          mem_load;

    logic [`ADDR_W-1:0] load_addrs [N_LOADS];
    int                 cycle_count = 0;
    int                 error_count;
    int                 fetch_count;
    int                 hit_count;
    int                 total_errors;

    icache_top DUT (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_ready      (cpu_ready),
        .cpu_data       (cpu_data),
        .mem_load_valid (mem_load_valid),
        .mem_load       (mem_load)
    );

    icache_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_ready      (cpu_ready),
        .cpu_data       (cpu_data),
        .mem_load_valid (mem_load_valid),
        .mem_load       (mem_load),
        .error_count    (error_count),
        .fetch_count    (fetch_count),
        .hit_count      (hit_count)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    // low index bits come from the loop count, so four addresses share each index
    task automatic load_memory();
        logic [31:0] r;
        for (int i = 0; i < N_LOADS; i++)
        begin
            r = $urandom();
            load_addrs[i]  = {r[9:0], i[5:0]};
            mem_load_valid = 1'b1;
            mem_load.addr  = load_addrs[i];
            mem_load.data  = $urandom();
            @(posedge clk);
            #2;
        end
        mem_load_valid = 1'b0;
    endtask

    // hold the request until cpu_ready, then release after the edge
    task automatic fetch_word(input logic [`ADDR_W-1:0] addr);
        cpu_req_valid = 1'b1;
        cpu_req_addr  = addr;
        @(negedge clk);
        while (!cpu_ready)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        cpu_req_valid = 1'b0;
    endtask

    task automatic random_fetches(input int count);
        int pick;
        for (int n = 0; n < count; n++)
        begin
            pick = $urandom_range(N_LOADS - 1, 0);
            fetch_word(load_addrs[pick]);
        end
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles with fetches still outstanding", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(75));
        rst            = 1'b1;
        cpu_req_valid  = 1'b0;
        cpu_req_addr   = '0;
        mem_load_valid = 1'b0;
        mem_load       = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        load_memory();

        // cold miss, then a hit on the same word
        fetch_word(load_addrs[0]);
        fetch_word(load_addrs[0]);
        // entries 0 and 16 share index 0 with different tags
        fetch_word(load_addrs[16]);
        fetch_word(load_addrs[0]);
        fetch_word(load_addrs[16]);
        fetch_word(load_addrs[16]);

        random_fetches(N_RANDOM);

        repeat (4) @(posedge clk);
        total_errors = error_count;
        if (fetch_count != N_FETCHES)
        begin
            $display("checker saw %0d fetches but %0d were issued", fetch_count, N_FETCHES);
            total_errors = total_errors + 1;
        end
        $display("fetches %0d, hits %0d, errors %0d", fetch_count, hit_count, total_errors);
        if (total_errors == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog/icache_array.sv */
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_array (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`INDEX_W-1:0]     rd_index,
    output icache_pkg::cache_line_t rd_line,
    input  logic                    fill_en,
    input  logic [`INDEX_W-1:0]     fill_index,
    input  icache_pkg::cache_line_t fill_line
);

    logic [`LINES-1:0] valid_q;
    logic [`TAG_W-1:0]  tag_mem  [`LINES];
    logic [`DATA_W-1:0] data_mem [`LINES];

    // valid bits are the only state cleared by reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
        end
        else if (fill_en)
        begin
            valid_q[fill_index] <= fill_line.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            tag_mem[fill_index]  <= fill_line.tag;
            data_mem[fill_index] <= fill_line.data;
        end
    end

    // registered read, a fill to the same index is forwarded
    // so the re-read after a miss sees the new line
    always_ff @(posedge clk)
    begin
        if (fill_en && (fill_index == rd_index))
        begin
            rd_line <= fill_line;
        end
        else
        begin
            rd_line.valid <= valid_q[rd_index];
            rd_line.tag   <= tag_mem[rd_index];
            rd_line.data  <= data_mem[rd_index];
        end
    end

endmodule

/* verilog/icache_ctrl.sv */
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    // fetch requester
    input  logic                    cpu_req_valid,
    input  logic [`ADDR_W-1:0]      cpu_req_addr,
    output logic                    cpu_ready,
    output logic [`DATA_W-1:0]      cpu_data,
    // line storage
    output logic [`INDEX_W-1:0]     rd_index,
    input  icache_pkg::cache_line_t rd_line,
    output logic                    fill_en,
    output logic [`INDEX_W-1:0]     fill_index,
    output icache_pkg::cache_line_t fill_line,
    // instruction memory
    output logic                    mem_req_valid,
    output icache_pkg::fetch_req_t  mem_req,
    input  logic                    mem_resp_valid,
    input  logic [`DATA_W-1:0]      mem_resp_data
);

    import icache_pkg::*;

    icache_state_t state_q;
    icache_state_t state_d;
    fetch_req_t    req_q;

    logic [`INDEX_W-1:0] req_index;
    logic [`TAG_W-1:0]   req_tag;
    logic                hit;

    assign req_index = req_q.addr[`INDEX_W-1:0];
    assign req_tag   = req_q.addr[`ADDR_W-1:`INDEX_W];

    // rd_line holds the line read at the previous edge
    assign hit = rd_line.valid && (rd_line.tag == req_tag);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // request is only captured on acceptance
    always_ff @(posedge clk)
    begin
        if (state_q == IDLE && cpu_req_valid)
        begin
            req_q.addr <= cpu_req_addr;
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
            begin
                if (cpu_req_valid)
                begin
                    state_d = COMPARE;
                end
            end
            COMPARE:
            begin
                if (hit)
                begin
                    state_d = IDLE;
                end
                else
                begin
                    state_d = ALLOCATE;
                end
            end
            ALLOCATE:
            begin
                // fill and re-read happen on the response edge
                if (mem_resp_valid)
                begin
                    state_d = COMPARE;
                end
            end
            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

    // index straight from the port while idle, so a hit takes one cycle
    assign rd_index = (state_q == IDLE) ? cpu_req_addr[`INDEX_W-1:0] : req_index;

    assign cpu_ready = (state_q == COMPARE) && hit;
    assign cpu_data  = rd_line.data;

    assign mem_req_valid = (state_q == ALLOCATE);
    assign mem_req       = req_q;

    assign fill_en         = (state_q == ALLOCATE) && mem_resp_valid;
    assign fill_index      = req_index;
    assign fill_line.valid = 1'b1;
    assign fill_line.tag   = req_tag;
    assign fill_line.data  = mem_resp_data;

endmodule

/* verilog/icache_pkg.sv */
`include "icache_consts.svh"

package icache_pkg;

    // controller states
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        COMPARE  = 2'd1,
        ALLOCATE = 2'd2
    } icache_state_t;

    // latched fetch, also the memory request
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
    } fetch_req_t;

    // one cache line: valid + tag + data = 45 bits
    typedef struct packed {
        logic               valid;
        logic [`TAG_W-1:0]  tag;
        logic [`DATA_W-1:0] data;
    } cache_line_t;

    // loader write into instruction memory
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
    } mem_load_t;

endpackage

/* verilog/icache_top.sv */
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top (
    input  logic                  clk,
    input  logic                  rst,
    // fetch port
    input  logic                  cpu_req_valid,
    input  logic [`ADDR_W-1:0]    cpu_req_addr,
    output logic                  cpu_ready,
    output logic [`DATA_W-1:0]    cpu_data,
    // loader port
    input  logic                  mem_load_valid,
    input  icache_pkg::mem_load_t mem_load
);

    import icache_pkg::*;

    logic [`INDEX_W-1:0] rd_index;
    cache_line_t         rd_line;
    logic                fill_en;
    logic [`INDEX_W-1:0] fill_index;
    cache_line_t         fill_line;

    logic                mem_req_valid;
    fetch_req_t          mem_req;
    logic                mem_resp_valid;
    logic [`DATA_W-1:0]  mem_resp_data;

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_ready      (cpu_ready),
        .cpu_data       (cpu_data),
        .rd_index       (rd_index),
        .rd_line        (rd_line),
        .fill_en        (fill_en),
        .fill_index     (fill_index),
        .fill_line      (fill_line),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    icache_array u_array (
        .clk        (clk),
        .rst        (rst),
        .rd_index   (rd_index),
        .rd_line    (rd_line),
        .fill_en    (fill_en),
        .fill_index (fill_index),
        .fill_line  (fill_line)
    );

    instr_mem u_mem (
        .clk            (clk),
        .rst            (rst),
        .mem_load_valid (mem_load_valid),
        .mem_load       (mem_load),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

endmodule

/* verilog/instr_mem.sv */
`timescale 1ns/1ps
`include "icache_consts.svh"

module instr_mem (
    input  logic                   clk,
    input  logic                   rst,
    // loader
    input  logic                   mem_load_valid,
    input  icache_pkg::mem_load_t  mem_load,
    // cache side
    input  logic                   mem_req_valid,
    input  icache_pkg::fetch_req_t mem_req,
    output logic                   mem_resp_valid,
    output logic [`DATA_W-1:0]     mem_resp_data
);

    localparam int CNT_W = $clog2(`MEM_LAT + 1);

    logic [`DATA_W-1:0] mem [2**`ADDR_W];
    logic [CNT_W-1:0]   cnt_q;
    logic [`ADDR_W-1:0] addr_q;
    logic               start;

    always_ff @(posedge clk)
    begin
        if (mem_load_valid)
        begin
            mem[mem_load.addr] <= mem_load.data;
        end
    end

    // nonzero count means a read is in flight; the response cycle is
    // excluded since the request is still held high there
    assign start = (cnt_q == '0) && mem_req_valid && !mem_resp_valid;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt_q          <= '0;
            mem_resp_valid <= 1'b0;
        end
        else
        begin
            mem_resp_valid <= 1'b0;
            if (start)
            begin
                cnt_q <= CNT_W'(`MEM_LAT - 1);
            end
            else if (cnt_q == CNT_W'(1))
            begin
                // strobe lands MEM_LAT cycles after the request
                cnt_q          <= '0;
                mem_resp_valid <= 1'b1;
            end
            else if (cnt_q != '0)
            begin
                cnt_q <= cnt_q - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            addr_q <= mem_req.addr;
        end
        if (cnt_q == CNT_W'(1))
        begin
            mem_resp_data <= mem[addr_q];
        end
    end

endmodule
